//--- files.f
rtl/timerPkg.sv
rtl/eventConditioner.sv
rtl/timerRegs.sv
rtl/timerCore.sv
rtl/irqStatus.sv
rtl/pwmOutput.sv
rtl/timerTop.sv
test/timerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the timer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module timerTb \
  -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtimerTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0

//--- test/timerTb.sv
`timescale 1ns/1ps

module timerTb;

  localparam int opWr      = 0;  // Bus write
  localparam int opRd      = 1;  // Read and compare
  localparam int opRdMax   = 2;  // Read, value must not exceed exp
  localparam int opHold    = 3;  // Two reads must match
  localparam int opDiff    = 4;  // Read must differ from the held value
  localparam int opEv      = 5;  // Drive one event input
  localparam int opIdle    = 6;
  localparam int opPwm     = 7;  // Count high cycles over one period
  localparam int opIrqWait = 8;
  localparam int opIrqIs   = 9;
  localparam int opDone    = 10; // Closes a test

  logic        CPUbus;
  logic        rstN;
  logic        sel;
  logic        write;
  logic        transActive;
  logic [5:0]  addr;
  logic [31:0] wdata;
  logic [2:0]  evnt;
  logic [31:0] rdata;
  logic [1:0]  pwm;
  logic        irq;

  int          opQ[$];
  int          idxQ[$];
  logic [31:0] dataQ[$];
  logic [31:0] expQ[$];
  logic [31:0] lcgState = 32'hbe85;
  logic [31:0] lastVal;
  int          errCount;
  int          testErr;
  int          checkCount;
  int          testCount;

  timerTop u_dut (
    .CPUbus      (CPUbus),
    .rstN        (rstN),
    .sel         (sel),
    .write       (write),
    .transActive (transActive),
    .addr        (addr),
    .wdata       (wdata),
    .evnt        (evnt),
    .rdata       (rdata),
    .pwm         (pwm),
    .irq         (irq)
  );

  initial begin
    CPUbus = 1'b0;
    forever #50 CPUbus = ~CPUbus;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic string testTitle(input int n);
    case (n)
      1:       return "register readback";
      2:       return "counting";
      3:       return "PWM duty and polarity";
      4:       return "event filter and interrupt";
      5:       return "matrix start and gate";
      default: return "period interrupt";
    endcase
  endfunction

  task automatic addStep(input int op, input int idx, input logic [31:0] data,
                         input logic [31:0] exp);
    opQ.push_back(op);
    idxQ.push_back(idx);
    dataQ.push_back(data);
    expQ.push_back(exp);
  endtask

  task automatic busWrite(input int idx, input logic [31:0] data);
    @(posedge CPUbus);
    sel         <= 1'b1;  // Address phase
    write       <= 1'b1;
    transActive <= 1'b1;
    addr        <= {idx[3:0], 2'b00};
    @(posedge CPUbus);
    sel         <= 1'b0;  // Data phase
    write       <= 1'b0;
    transActive <= 1'b0;
    wdata       <= data;
    @(posedge CPUbus);
  endtask

  task automatic busRead(input int idx, output logic [31:0] data);
    @(posedge CPUbus);
    sel         <= 1'b1;
    write       <= 1'b0;
    transActive <= 1'b1;
    addr        <= {idx[3:0], 2'b00};
    @(posedge CPUbus);
    sel         <= 1'b0;
    transActive <= 1'b0;
    @(negedge CPUbus);  // rdata settled in the data phase
    data = rdata;
  endtask

  task automatic reportValue(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    errCount++;
    testErr++;
    $display("** Error at %0d ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
  endtask

  task automatic reportFail(input string what);
    errCount++;
    testErr++;
    $display("Failure at %0d ns: %s", $time, what);
  endtask

  task automatic runStep(input int op, input int idx, input logic [31:0] data,
                         input logic [31:0] exp);
    logic [31:0] got;
    int          hits;
    bit          seen;
    case (op)
      opWr: busWrite(idx, data);
      opRd: begin
        busRead(idx, got);
        checkCount++;
        assert (got === exp) else reportValue($sformatf("word %0d", idx), got, exp);
      end
      opRdMax: begin
        busRead(idx, got);
        checkCount++;
        assert (got <= exp) else reportValue($sformatf("word %0d above limit", idx), got, exp);
      end
      opHold: begin
        busRead(idx, lastVal);
        busRead(idx, got);
        checkCount++;
        assert (got === lastVal) else reportValue($sformatf("word %0d moved", idx), got, lastVal);
      end
      opDiff: begin
        busRead(idx, got);
        checkCount++;
        assert (got !== lastVal) else
          reportFail($sformatf("word %0d stayed at 0x%0h", idx, got));
      end
      opEv: begin
        @(posedge CPUbus);
        evnt[idx] <= data[0];
      end
      opIdle: repeat (data) @(posedge CPUbus);
      opPwm: begin
        repeat (data + 2) @(posedge CPUbus);  // Skip the first partial period
        hits = 0;
        for (int i = 0; i <= data; i++) begin
          @(negedge CPUbus);
          if (pwm[idx]) hits++;
        end
        checkCount++;
        assert (hits == exp) else reportValue($sformatf("pwm[%0d] high cycles", idx), hits, exp);
      end
      opIrqWait: begin
        seen = 1'b0;
        for (int i = 0; i < data && !seen; i++) begin
          @(negedge CPUbus);
          seen = (irq === exp[0]);
        end
        checkCount++;
        assert (seen) else
          reportFail($sformatf("irq did not reach %0d within %0d cycles", exp[0], data));
      end
      opIrqIs: begin
        @(negedge CPUbus);
        checkCount++;
        assert (irq === exp[0]) else reportValue("irq", irq, exp);
      end
      default: begin
        testCount++;
        $display("Test %0d %s: %s, %0d errors", idx, testTitle(idx),
                 (testErr == 0) ? "ok" : "failed", testErr);
        testErr = 0;
      end
    endcase
  endtask

  task automatic buildTable();
    logic [31:0] prd;
    logic [31:0] c0;
    logic [31:0] c1;
    prd = 32'd20;
    c0  = (nextRand() >> 16) % prd;  // Compare values below the period
    c1  = (nextRand() >> 16) % prd;
    addStep(opWr, 1, 32'h0001_2345, 0);
    addStep(opRd, 1, 0, 32'h2345);
    addStep(opWr, 2, 32'habcd_1234, 0);
    addStep(opRd, 2, 0, 32'h1234);
    addStep(opWr, 3, 32'h0000_ffff, 0);
    addStep(opRd, 3, 0, 32'hffff);
    addStep(opWr, 6, 32'hffff_ffff, 0);
    addStep(opRd, 6, 0, 32'h7fff);
    addStep(opWr, 7, 32'h0000_01a5, 0);
    addStep(opRd, 7, 0, 32'ha5);
    addStep(opWr, 8, 32'hffff_fffe, 0);
    addStep(opRd, 8, 0, 32'h2);
    addStep(opWr, 10, 32'h3f, 0);
    addStep(opRd, 10, 0, 32'h1f);
    addStep(opWr, 11, 32'h7, 0);
    addStep(opRd, 11, 0, 32'h3);
    addStep(opWr, 4, 32'h4, 0);
    addStep(opRd, 4, 0, 0);
    addStep(opWr, 15, 32'hffff_ffff, 0);
    addStep(opRd, 15, 0, 0);
    addStep(opRd, 12, 0, 0);
    addStep(opRd, 5, 0, 0);
    addStep(opWr, 6, 0, 0);
    addStep(opWr, 7, 0, 0);
    addStep(opWr, 8, 0, 0);
    addStep(opWr, 10, 0, 0);
    addStep(opWr, 11, 0, 0);
    addStep(opDone, 1, 0, 0);
    addStep(opWr, 1, prd, 0);
    addStep(opWr, 4, 32'h1, 0);
    addStep(opRdMax, 0, 0, prd);
    addStep(opIdle, 0, 7, 0);
    addStep(opRdMax, 0, 0, prd);
    addStep(opIdle, 0, 13, 0);
    addStep(opRdMax, 0, 0, prd);
    addStep(opIdle, 0, 5, 0);
    addStep(opRdMax, 0, 0, prd);
    addStep(opRd, 5, 0, 32'h1);
    addStep(opWr, 4, 32'h2, 0);
    addStep(opHold, 0, 0, 0);
    addStep(opRd, 5, 0, 0);
    addStep(opDone, 2, 0, 0);
    addStep(opWr, 2, c0, 0);
    addStep(opWr, 3, c1, 0);
    addStep(opWr, 11, 32'h2, 0);
    addStep(opWr, 4, 32'h5, 0);  // Clear and run
    addStep(opPwm, 0, prd, prd - c0);
    addStep(opPwm, 1, prd, c1 + 1);
    addStep(opWr, 4, 32'h2, 0);
    addStep(opWr, 11, 0, 0);
    addStep(opDone, 3, 0, 0);
    addStep(opWr, 6, 32'h7, 0);  // Filter 3, rising
    addStep(opWr, 10, 32'h1, 0);
    addStep(opIdle, 0, 2, 0);
    addStep(opEv, 0, 1, 0);
    addStep(opIdle, 0, 3, 0);
    addStep(opEv, 0, 0, 0);
    addStep(opIdle, 0, 12, 0);
    addStep(opRd, 9, 0, 0);
    addStep(opIrqIs, 0, 0, 0);
    addStep(opEv, 0, 1, 0);
    addStep(opIrqWait, 0, 15, 1);
    addStep(opIdle, 0, 2, 0);
    addStep(opEv, 0, 0, 0);
    addStep(opRd, 9, 0, 32'h1);
    addStep(opWr, 9, 32'h1, 0);
    addStep(opRd, 9, 0, 0);
    addStep(opIrqIs, 0, 0, 0);
    addStep(opIdle, 0, 10, 0);
    addStep(opWr, 10, 0, 0);
    addStep(opDone, 4, 0, 0);
    addStep(opWr, 6, 32'h80, 0);  // Event 1 rising
    addStep(opWr, 8, 32'h1, 0);
    addStep(opWr, 7, 32'h2, 0);
    addStep(opRd, 5, 0, 0);
    addStep(opEv, 1, 1, 0);
    addStep(opIdle, 0, 3, 0);
    addStep(opEv, 1, 0, 0);
    addStep(opIdle, 0, 3, 0);
    addStep(opRd, 5, 0, 32'h1);
    addStep(opWr, 7, 32'hc2, 0);  // Gate on event 2
    addStep(opHold, 0, 0, 0);
    addStep(opEv, 2, 1, 0);
    addStep(opIdle, 0, 4, 0);
    addStep(opDiff, 0, 0, 0);
    addStep(opDone, 5, 0, 0);
    addStep(opWr, 7, 0, 0);
    addStep(opWr, 9, 32'h1f, 0);
    addStep(opWr, 10, 32'h10, 0);
    addStep(opIrqWait, 0, 2 * (prd + 1), 1);
    addStep(opRd, 9, 0, 32'h10);
    addStep(opWr, 4, 32'h2, 0);
    addStep(opWr, 10, 0, 0);
    addStep(opWr, 9, 32'h1f, 0);
    addStep(opIrqIs, 0, 0, 0);
    addStep(opDone, 6, 0, 0);
  endtask

  initial begin
    rstN        = 1'b0;
    sel         = 1'b0;
    write       = 1'b0;
    transActive = 1'b0;
    addr        = '0;
    wdata       = '0;
    evnt        = '0;
    errCount    = 0;
    testErr     = 0;
    checkCount  = 0;
    testCount   = 0;
    lastVal     = '0;
    repeat (3) @(posedge CPUbus);
    rstN <= 1'b1;
    buildTable();
    for (int i = 0; i < opQ.size(); i++) begin
      runStep(opQ[i], idxQ[i], dataQ[i], expQ[i]);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog against a hung run
  initial begin
    for (int cyc = 0; cyc < 5000; cyc++) begin
      @(posedge CPUbus);
    end
    $display("Simulation ran past its cycle limit without finishing");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- rtl/timerTop.sv
`timescale 1ns/1ps

module timerTop #(
  localparam int cntW  = timerPkg::tmWidth,
  localparam int chN   = timerPkg::pwmCount,
  localparam int flagN = timerPkg::isrPmUp + 1
) (
  input  logic                          CPUbus,
  input  logic                          rstN,
  input  logic                          sel,
  input  logic                          write,
  input  logic                          transActive,
  input  logic [timerPkg::addrWidth-1:0] addr,
  input  logic [timerPkg::busWidth-1:0]  wdata,
  input  logic [2:0]                    evnt,
  output logic [timerPkg::busWidth-1:0]  rdata,
  output logic [chN-1:0]                pwm,
  output logic                          irq
);

  logic [cntW-1:0]          tmVal;
  logic [cntW-1:0]          tmPr;
  logic [chN-1:0][cntW-1:0] tmCmp;
  logic                     runSet;
  logic                     runClr;
  logic                     tmClr;
  logic [14:0]              ecr;
  logic [7:0]               cmc;
  logic [1:0]               tms;
  logic [flagN-1:0]         isr;
  logic [flagN-1:0]         isrClr;
  logic [flagN-1:0]         iec;
  logic [chN-1:0]           plc;
  logic [2:0]               evEdge;
  logic [2:0]               evLevel;
  logic                     running;
  logic                     cntEn;
  logic [chN-1:0]           cmpMatch;
  logic                     prdMatch;

  // Five ECR bits per event
  for (genvar ev = 0; ev < 3; ev++) begin : genEvent
    eventConditioner uEvent (
      .CPUbus    (CPUbus),
      .rstN      (rstN),
      .evIn      (evnt[ev]),
      .filtCode  (ecr[5*ev +: 2]),
      .edgeCode  (ecr[5*ev+2 +: 2]),
      .lvlInv    (ecr[5*ev+4]),
      .edgePulse (evEdge[ev]),
      .level     (evLevel[ev])
    );
  end

  timerRegs uRegs (
    .CPUbus      (CPUbus),
    .rstN        (rstN),
    .sel         (sel),
    .write       (write),
    .transActive (transActive),
    .addr        (addr),
    .wdata       (wdata),
    .tmVal       (tmVal),
    .running     (running),
    .isr         (isr),
    .rdata       (rdata),
    .tmPr        (tmPr),
    .tmCmp       (tmCmp),
    .runSet      (runSet),
    .runClr      (runClr),
    .tmClr       (tmClr),
    .ecr         (ecr),
    .cmc         (cmc),
    .tms         (tms),
    .isrClr      (isrClr),
    .iec         (iec),
    .plc         (plc)
  );

  timerCore uCore (
    .CPUbus    (CPUbus),
    .rstN      (rstN),
    .evEdge    (evEdge),
    .evLevel   (evLevel),
    .cmc       (cmc),
    .tms       (tms),
    .runSet    (runSet),
    .runClr    (runClr),
    .tmClr     (tmClr),
    .tmPr      (tmPr),
    .tmCmp     (tmCmp),
    .tmVal     (tmVal),
    .running   (running),
    .cntEn     (cntEn),
    .cmpMatch  (cmpMatch),
    .prdMatch  (prdMatch),
    .zeroMatch ()
  );

  irqStatus uIrq (
    .CPUbus   (CPUbus),
    .rstN     (rstN),
    .evEdge   (evEdge),
    .cmpMatch (cmpMatch),
    .prdMatch (prdMatch),
    .running  (running),
    .cntEn    (cntEn),
    .iec      (iec),
    .isrClr   (isrClr),
    .isr      (isr),
    .irq      (irq)
  );

  pwmOutput uPwm (
    .CPUbus   (CPUbus),
    .rstN     (rstN),
    .running  (running),
    .cntEn    (cntEn),
    .cmpMatch (cmpMatch),
    .prdMatch (prdMatch),
    .tmVal    (tmVal),
    .tmCmp    (tmCmp),
    .plc      (plc),
    .pwm      (pwm)
  );

endmodule

//--- rtl/pwmOutput.sv
`timescale 1ns/1ps

module pwmOutput (
  input  logic                                                CPUbus,
  input  logic                                                rstN,
  input  logic                                                running,
  input  logic                                                cntEn,
  input  logic [timerPkg::pwmCount-1:0]                       cmpMatch,
  input  logic                                                prdMatch,
  input  logic [timerPkg::tmWidth-1:0]                        tmVal,
  input  logic [timerPkg::pwmCount-1:0][timerPkg::tmWidth-1:0] tmCmp,
  input  logic [timerPkg::pwmCount-1:0]                       plc,
  output logic [timerPkg::pwmCount-1:0]                       pwm
);
  import timerPkg::*;

  logic [pwmCount-1:0] pwmQ;

  always_ff @(posedge CPUbus) begin
    if (!rstN) begin
      pwmQ <= '0;
    end else begin
      for (int ch = 0; ch < pwmCount; ch++) begin
        if (running) begin
          if (cntEn) begin
            if (cmpMatch[ch]) begin
              pwmQ[ch] <= 1'b1;
            end else if (prdMatch) begin
              pwmQ[ch] <= 1'b0;
            end
          end
        end else begin
          pwmQ[ch] <= (tmVal > tmCmp[ch]);  // Static level while stopped
        end
      end
    end
  end

  assign pwm = pwmQ ^ plc;  // Passive level select

endmodule

//--- rtl/irqStatus.sv
`timescale 1ns/1ps

module irqStatus (
  input  logic                          CPUbus,
  input  logic                          rstN,
  input  logic [2:0]                    evEdge,
  input  logic [timerPkg::pwmCount-1:0] cmpMatch,
  input  logic                          prdMatch,
  input  logic                          running,
  input  logic                          cntEn,
  input  logic [timerPkg::isrPmUp:0]    iec,
  input  logic [timerPkg::isrPmUp:0]    isrClr,
  output logic [timerPkg::isrPmUp:0]    isr,
  output logic                          irq
);
  import timerPkg::*;

  logic [isrPmUp:0] cond;
  logic [isrPmUp:0] setVec;

  always_comb begin
    cond          = '0;
    cond[isrEv0]  = evEdge[0];
    cond[isrEv1]  = evEdge[1];
    cond[isrEv2]  = evEdge[2];
    cond[isrCmUp] = running & cntEn & (|cmpMatch);  // Any channel
    cond[isrPmUp] = running & cntEn & prdMatch;
  end

  assign setVec = cond & iec;

  always_ff @(posedge CPUbus) begin
    if (!rstN) begin
      isr <= '0;
    end else begin
      isr <= setVec | (isr & ~isrClr);  // Set beats clear
    end
  end

  assign irq = |isr;

endmodule

//--- rtl/timerCore.sv
`timescale 1ns/1ps

module timerCore (
  input  logic                                                CPUbus,
  input  logic                                                rstN,
  input  logic [2:0]                                          evEdge,
  input  logic [2:0]                                          evLevel,
  input  logic [7:0]                                          cmc,
  input  logic [1:0]                                          tms,
  input  logic                                                runSet,
  input  logic                                                runClr,
  input  logic                                                tmClr,
  input  logic [timerPkg::tmWidth-1:0]                        tmPr,
  input  logic [timerPkg::pwmCount-1:0][timerPkg::tmWidth-1:0] tmCmp,
  output logic [timerPkg::tmWidth-1:0]                        tmVal,
  output logic                                                running,
  output logic                                                cntEn,
  output logic [timerPkg::pwmCount-1:0]                       cmpMatch,
  output logic                                                prdMatch,
  output logic                                                zeroMatch
);
  import timerPkg::*;

  logic evStart;
  logic evStop;
  logic evCnt;
  logic evGate;
  logic startHit;
  logic stopHit;
  logic clrHit;

  // Matrix select code, 0 is none and 1 to 3 pick event 0 to 2
  function automatic logic pickEv(input logic [1:0] code, input logic [2:0] ev);
    logic hit;
    case (code)
      2'd1:    hit = ev[0];
      2'd2:    hit = ev[1];
      2'd3:    hit = ev[2];
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  assign evStart = pickEv(cmc[1:0], evEdge);
  assign evStop  = pickEv(cmc[3:2], evEdge);
  assign evCnt   = pickEv(cmc[5:4], evEdge);
  assign evGate  = pickEv(cmc[7:6], evLevel);  // Gate follows the level

  assign startHit = runSet | evStart;
  assign stopHit  = runClr | evStop;
  assign clrHit   = tmClr | (startHit & tms[0]) | (stopHit & tms[1]);

  assign cntEn = (cmc[7:6] != 2'd0) ? evGate :
                 (cmc[5:4] != 2'd0) ? evCnt  : 1'b1;

  assign prdMatch  = (tmVal == tmPr);
  assign zeroMatch = (tmVal == '0);

  always_comb begin
    for (int ch = 0; ch < pwmCount; ch++) begin
      cmpMatch[ch] = (tmVal == tmCmp[ch]);
    end
  end

  always_ff @(posedge CPUbus) begin
    if (!rstN) begin
      running <= 1'b0;
      tmVal   <= '0;
    end else begin
      if (stopHit) begin
        running <= 1'b0;  // Stop wins
      end else if (startHit) begin
        running <= 1'b1;
      end

      if (clrHit) begin
        tmVal <= '0;
      end else if (running && cntEn) begin
        if (prdMatch) begin
          tmVal <= '0;  // Wrap at period
        end else begin
          tmVal <= tmVal + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/timerRegs.sv
`timescale 1ns/1ps

module timerRegs (
  input  logic                                                CPUbus,
  input  logic                                                rstN,
  input  logic                                                sel,
  input  logic                                                write,
  input  logic                                                transActive,
  input  logic [timerPkg::addrWidth-1:0]                      addr,
  input  logic [timerPkg::busWidth-1:0]                       wdata,
  input  logic [timerPkg::tmWidth-1:0]                        tmVal,
  input  logic                                                running,
  input  logic [timerPkg::isrPmUp:0]                          isr,
  output logic [timerPkg::busWidth-1:0]                       rdata,
  output logic [timerPkg::tmWidth-1:0]                        tmPr,
  output logic [timerPkg::pwmCount-1:0][timerPkg::tmWidth-1:0] tmCmp,
  output logic                                                runSet,
  output logic                                                runClr,
  output logic                                                tmClr,
  output logic [14:0]                                         ecr,
  output logic [7:0]                                          cmc,
  output logic [1:0]                                          tms,
  output logic [timerPkg::isrPmUp:0]                          isrClr,
  output logic [timerPkg::isrPmUp:0]                          iec,
  output logic [timerPkg::pwmCount-1:0]                       plc
);
  import timerPkg::*;

  logic                       wrPend;   // Data phase of a write
  logic [addrWidth-1:wordLsb] wordIdx;  // Address from the address phase
  logic                       trsHit;
  logic                       isrHit;

  // Command pulses act in the data phase itself
  assign trsHit = wrPend && (wordIdx == regTrs);
  assign isrHit = wrPend && (wordIdx == regIsr);

  assign runSet = trsHit & wdata[0];
  assign runClr = trsHit & wdata[1];
  assign tmClr  = trsHit & wdata[2];
  assign isrClr = isrHit ? wdata[isrPmUp:0] : '0;

  always_ff @(posedge CPUbus) begin
    if (!rstN) begin
      wrPend  <= 1'b0;
      wordIdx <= '0;
      tmPr    <= '0;
      tmCmp   <= '0;
      ecr     <= '0;
      cmc     <= '0;
      tms     <= '0;
      iec     <= '0;
      plc     <= '0;
    end else begin
      wrPend <= sel & transActive & write;
      if (sel & transActive) begin
        wordIdx <= addr[addrWidth-1:wordLsb];
      end
      if (wrPend) begin
        case (wordIdx)
          regTmPr:   tmPr     <= wdata[tmWidth-1:0];
          regTmCmp0: tmCmp[0] <= wdata[tmWidth-1:0];
          regTmCmp1: tmCmp[1] <= wdata[tmWidth-1:0];
          regEcr:    ecr      <= wdata[14:0];
          regCmc:    cmc      <= wdata[7:0];
          regTms:    tms      <= wdata[1:0];
          regIec:    iec      <= wdata[isrPmUp:0];
          regPlc:    plc      <= wdata[pwmCount-1:0];
          default:   ;  // Read-only or command words
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (wordIdx)
      regTmVal:  rdata[tmWidth-1:0]  = tmVal;
      regTmPr:   rdata[tmWidth-1:0]  = tmPr;
      regTmCmp0: rdata[tmWidth-1:0]  = tmCmp[0];
      regTmCmp1: rdata[tmWidth-1:0]  = tmCmp[1];
      regTrSt:   rdata[0]            = running;
      regEcr:    rdata[14:0]         = ecr;
      regCmc:    rdata[7:0]          = cmc;
      regTms:    rdata[1:0]          = tms;
      regIsr:    rdata[isrPmUp:0]    = isr;
      regIec:    rdata[isrPmUp:0]    = iec;
      regPlc:    rdata[pwmCount-1:0] = plc;
      default:   rdata               = '0;  // TRS and unmapped words
    endcase
  end

endmodule

//--- rtl/eventConditioner.sv
`timescale 1ns/1ps

module eventConditioner (
  input  logic       CPUbus,
  input  logic       rstN,
  input  logic       evIn,
  input  logic [1:0] filtCode,
  input  logic [1:0] edgeCode,
  input  logic       lvlInv,
  output logic       edgePulse,
  output logic       level
);
  import timerPkg::*;

  logic [2:0] filtLen;
  logic [2:0] filtCnt;
  logic       filtQ;
  logic       filtDel;
  logic       riseHit;
  logic       fallHit;

  always_comb begin
    case (filtCode)
      2'd0:    filtLen = filtLen0;
      2'd1:    filtLen = filtLen1;
      2'd2:    filtLen = filtLen2;
      default: filtLen = filtLen3;
    endcase
  end

  // Input must differ for filtLen + 1 cycles in a row
  always_ff @(posedge CPUbus) begin
    if (!rstN) begin
      filtQ   <= 1'b0;
      filtCnt <= '0;
    end else if (evIn != filtQ) begin
      if (filtCnt >= filtLen) begin
        filtQ   <= evIn;
        filtCnt <= '0;
      end else begin
        filtCnt <= filtCnt + 3'd1;  // Still settling
      end
    end else begin
      filtCnt <= '0;  // Glitch gone
    end
  end

  assign riseHit = filtQ & ~filtDel;
  assign fallHit = ~filtQ & filtDel;

  always_ff @(posedge CPUbus) begin
    if (!rstN) begin
      filtDel   <= 1'b0;
      edgePulse <= 1'b0;
      level     <= 1'b0;
    end else begin
      filtDel <= filtQ;
      level   <= filtQ ^ lvlInv;  // Active low when inverted
      case (edgeCode)
        edgeNone: edgePulse <= 1'b0;
        edgeRise: edgePulse <= riseHit;
        edgeFall: edgePulse <= fallHit;
        edgeBoth: edgePulse <= riseHit | fallHit;
        default:  edgePulse <= 1'b0;
      endcase
    end
  end

endmodule

//--- rtl/timerPkg.sv
package timerPkg;

  localparam int tmWidth   = 16;  // Counter, period and compare
  localparam int pwmCount  = 2;
  localparam int busWidth  = 32;
  localparam int addrWidth = 6;   // Byte address
  localparam int wordLsb   = 2;

  // Register word indices
  localparam logic [addrWidth-wordLsb-1:0] regTmVal  = 0;  // Read only
  localparam logic [addrWidth-wordLsb-1:0] regTmPr   = 1;
  localparam logic [addrWidth-wordLsb-1:0] regTmCmp0 = 2;
  localparam logic [addrWidth-wordLsb-1:0] regTmCmp1 = 3;
  localparam logic [addrWidth-wordLsb-1:0] regTrs    = 4;  // Run set/clear, timer clear
  localparam logic [addrWidth-wordLsb-1:0] regTrSt   = 5;
  localparam logic [addrWidth-wordLsb-1:0] regEcr    = 6;
  localparam logic [addrWidth-wordLsb-1:0] regCmc    = 7;
  localparam logic [addrWidth-wordLsb-1:0] regTms    = 8;
  localparam logic [addrWidth-wordLsb-1:0] regIsr    = 9;  // Write one to clear
  localparam logic [addrWidth-wordLsb-1:0] regIec    = 10;
  localparam logic [addrWidth-wordLsb-1:0] regPlc    = 11;

  localparam logic [1:0] edgeNone = 2'd0;
  localparam logic [1:0] edgeRise = 2'd1;
  localparam logic [1:0] edgeFall = 2'd2;
  localparam logic [1:0] edgeBoth = 2'd3;

  localparam logic [2:0] filtLen0 = 3'd0;  // Extra cycles per filter code
  localparam logic [2:0] filtLen1 = 3'd3;
  localparam logic [2:0] filtLen2 = 3'd5;
  localparam logic [2:0] filtLen3 = 3'd7;

  localparam int isrEv0  = 0;
  localparam int isrEv1  = 1;
  localparam int isrEv2  = 2;
  localparam int isrCmUp = 3;  // Compare match
  localparam int isrPmUp = 4;  // Period match

endpackage
